/* filelist.f */
pc_pkg.sv
ser_add.sv
shift_reg.sv
operand_loader.sv
serv_ctrl.sv
result_collector.sv
pc_unit_top.sv
pc_unit_chk.sv
tb_pc_unit.sv

/* operand_loader.sv */
module operand_loader import pc_pkg::*; (
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_start,
   input  logic       i_jump,
   input  logic       i_jal_or_jalr,
   input  logic       i_utype,
   input  logic       i_pc_rel,
   input  logic       i_trap,
   input  word_t      i_imm_word,
   input  word_t      i_buf_word,
   input  word_t      i_csr_pc_word,
   input  logic       i_ibus_cyc,
   output logic       o_pc_en,
   output logic [4:2] o_cnt,
   output logic [3:0] o_cnt_r,
   output logic       o_cnt_done,
   output logic       o_jump,
   output logic       o_jal_or_jalr,
   output logic       o_utype,
   output logic       o_pc_rel,
   output logic       o_trap,
   output logic       o_imm,
   output logic       o_buf,
   output logic       o_csr_pc,
   output logic       o_busy
);

   seq_state_t state;
   seq_state_t state_nxt;
   bit_idx_t   bit_idx;
   word_t      imm_sr;
   word_t      buf_sr;
   word_t      csr_pc_sr;
   logic       accept;
   logic       last_bit;

   assign accept   = (state == SEQ_IDLE) && i_start;
   assign last_bit = (bit_idx == bit_idx_t'(XLEN - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         SEQ_IDLE:  if (i_start) state_nxt = SEQ_SHIFT;
         SEQ_SHIFT: if (last_bit) state_nxt = SEQ_FETCH;
         SEQ_FETCH: if (!i_ibus_cyc) state_nxt = SEQ_IDLE;   // ack seen by controller
         default:   state_nxt = SEQ_IDLE;
      endcase
   end

   // reset lands in fetch so the first instruction fetch is modelled
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state   <= SEQ_FETCH;
         bit_idx <= '0;
      end else begin
         state <= state_nxt;
         if (o_pc_en) begin
            bit_idx <= bit_idx + bit_idx_t'(1);   // wraps back to 0 after bit 31
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_jump        <= 1'b0;
         o_jal_or_jalr <= 1'b0;
         o_utype       <= 1'b0;
         o_pc_rel      <= 1'b0;
         o_trap        <= 1'b0;
      end else if (accept) begin
         o_jump        <= i_jump;
         o_jal_or_jalr <= i_jal_or_jalr;
         o_utype       <= i_utype;
         o_pc_rel      <= i_pc_rel;
         o_trap        <= i_trap;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         imm_sr    <= i_imm_word;
         buf_sr    <= i_buf_word;
         csr_pc_sr <= i_csr_pc_word;
      end else if (o_pc_en) begin
         imm_sr    <= imm_sr >> 1;
         buf_sr    <= buf_sr >> 1;
         csr_pc_sr <= csr_pc_sr >> 1;
      end
   end

   assign o_pc_en    = (state == SEQ_SHIFT);
   assign o_cnt      = bit_idx[4:2];
   assign o_cnt_r    = 4'b0001 << bit_idx[1:0];   // phase within the nibble
   assign o_cnt_done = o_pc_en && last_bit;
   assign o_busy     = (state != SEQ_IDLE);

   assign o_imm    = imm_sr[0];
   assign o_buf    = buf_sr[0];
   assign o_csr_pc = csr_pc_sr[0];

endmodule

/* pc_pkg.sv */
package pc_pkg;

   // serial datapath width, fixed by the bit counter
   localparam int XLEN = 32;

   // pc values, operand words and the collected rd word
   typedef logic [XLEN-1:0] word_t;

   // serial bit index, 0 to 31
   typedef logic [$clog2(XLEN)-1:0] bit_idx_t;

   // loader sequencer
   typedef enum logic [1:0] {
      SEQ_IDLE,   // waiting for start
      SEQ_SHIFT,  // 32 bit cycles with pc_en high
      SEQ_FETCH   // fetch request pending at the new pc
   } seq_state_t;

endpackage

/* pc_unit_chk.sv */
module pc_unit_chk import pc_pkg::*; (
   input  logic  clk,
   input  logic  i_rst,
   input  logic  i_start,
   input  logic  i_pc_en,
   input  logic  i_busy,
   input  logic  i_done,
   input  logic  i_ibus_cyc,
   input  logic  i_ibus_ack,
   input  word_t i_ibus_adr
);

   int        err_cnt;   // read by the testbench at the end of the run
   logic [5:0] bits_left;  // bit cycles still due after an accepted start

   initial err_cnt = 0;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         bits_left <= 6'd0;
      end else if (i_start && !i_busy) begin
         bits_left <= 6'd32;
      end else if (bits_left != 6'd0) begin
         bits_left <= bits_left - 6'd1;
      end
   end

   done_while_busy: assert property (@(posedge clk) disable iff (i_rst) i_done |-> i_busy)
      else begin
         err_cnt++;
         $error("done high while busy is low");
      end

   // request holds until acked
   adr_stable: assert property (@(posedge clk) disable iff (i_rst)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
      else begin
         err_cnt++;
         $error("fetch request changed before ack");
      end

   no_fetch_in_shift: assert property (@(posedge clk) disable iff (i_rst)
      bits_left != 6'd0 |-> i_pc_en && !i_ibus_cyc)
      else begin
         err_cnt++;
         $error("fetch request raised during the shift");
      end

endmodule

bind pc_unit_top pc_unit_chk pc_unit_chk_inst (
   .clk        (clk),
   .i_rst      (i_rst),
   .i_start    (i_start),
   .i_pc_en    (pc_en),
   .i_busy     (o_busy),
   .i_done     (o_done),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_ibus_adr (o_ibus_adr)
);

/* pc_unit_top.sv */
module pc_unit_top import pc_pkg::*; #(
   parameter word_t RESET_PC = 32'd8
) (
   input  logic  clk,
   input  logic  i_rst,
   input  logic  i_start,
   input  logic  i_jump,
   input  logic  i_jal_or_jalr,
   input  logic  i_utype,
   input  logic  i_pc_rel,
   input  logic  i_trap,
   input  word_t i_imm_word,
   input  word_t i_buf_word,
   input  word_t i_csr_pc_word,
   input  logic  i_ibus_ack,
   output logic  o_busy,
   output logic  o_done,
   output word_t o_rd_word,
   output logic  o_misaligned,
   output word_t o_ibus_adr,
   output logic  o_ibus_cyc
);

   logic       pc_en;
   logic [4:2] cnt;
   logic [3:0] cnt_r;
   logic       cnt_done;
   logic       jump;
   logic       jal_or_jalr;
   logic       utype;
   logic       pc_rel;
   logic       trap;
   logic       imm_bit;
   logic       buf_bit;
   logic       csr_pc_bit;
   logic       rd_bit;
   logic       bad_pc;

   operand_loader operand_loader_inst (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_start       (i_start),
      .i_jump        (i_jump),
      .i_jal_or_jalr (i_jal_or_jalr),
      .i_utype       (i_utype),
      .i_pc_rel      (i_pc_rel),
      .i_trap        (i_trap),
      .i_imm_word    (i_imm_word),
      .i_buf_word    (i_buf_word),
      .i_csr_pc_word (i_csr_pc_word),
      .i_ibus_cyc    (o_ibus_cyc),
      .o_pc_en       (pc_en),
      .o_cnt         (cnt),
      .o_cnt_r       (cnt_r),
      .o_cnt_done    (cnt_done),
      .o_jump        (jump),
      .o_jal_or_jalr (jal_or_jalr),
      .o_utype       (utype),
      .o_pc_rel      (pc_rel),
      .o_trap        (trap),
      .o_imm         (imm_bit),
      .o_buf         (buf_bit),
      .o_csr_pc      (csr_pc_bit),
      .o_busy        (o_busy)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) serv_ctrl_inst (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_pc_en       (pc_en),
      .i_cnt         (cnt),
      .i_cnt_r       (cnt_r),
      .i_cnt_done    (cnt_done),
      .i_jump        (jump),
      .i_jal_or_jalr (jal_or_jalr),
      .i_utype       (utype),
      .i_pc_rel      (pc_rel),
      .i_trap        (trap),
      .i_imm         (imm_bit),
      .i_buf         (buf_bit),
      .i_csr_pc      (csr_pc_bit),
      .i_ibus_ack    (i_ibus_ack),
      .o_rd          (rd_bit),
      .o_bad_pc      (bad_pc),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc)
   );

   result_collector result_collector_inst (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_pc_en      (pc_en),
      .i_cnt        (cnt),
      .i_cnt_r      (cnt_r),
      .i_cnt_done   (cnt_done),
      .i_jump       (jump),
      .i_rd         (rd_bit),
      .i_bad_pc     (bad_pc),
      .o_rd_word    (o_rd_word),
      .o_misaligned (o_misaligned),
      .o_done       (o_done)
   );

endmodule

/* result_collector.sv */
module result_collector import pc_pkg::*; (
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_pc_en,
   input  logic [4:2] i_cnt,
   input  logic [3:0] i_cnt_r,
   input  logic       i_cnt_done,
   input  logic       i_jump,
   input  logic       i_rd,
   input  logic       i_bad_pc,
   output word_t      o_rd_word,
   output logic       o_misaligned,
   output logic       o_done
);

   word_t rd_sr;
   logic  at_bit1;

   assign at_bit1 = i_pc_en && (i_cnt == 3'd0) && i_cnt_r[1];

   // rd arrives lsb first, so it ends up aligned after 32 bits
   always_ff @(posedge clk) begin
      if (i_pc_en) begin
         rd_sr <= {i_rd, rd_sr[XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_misaligned <= 1'b0;
         o_done       <= 1'b0;
      end else begin
         o_done <= i_cnt_done && i_pc_en;
         if (at_bit1) begin
            o_misaligned <= i_jump & i_bad_pc;   // target bit 1 set
         end
      end
   end

   assign o_rd_word = rd_sr;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the pc unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_pc_unit -f filelist.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vtb_pc_unit +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* ser_add.sv */
module ser_add (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry;
   logic carry_nxt;

   assign o_q       = i_a ^ i_b ^ carry;
   assign carry_nxt = (i_a & i_b) | (carry & (i_a ^ i_b));

   // clr still lets the current bit use the stored carry
   always_ff @(posedge clk) begin
      if (i_rst || i_clr) begin
         carry <= 1'b0;
      end else begin
         carry <= carry_nxt;
      end
   end

endmodule

/* serv_ctrl.sv */
module serv_ctrl import pc_pkg::*; #(
   parameter word_t RESET_PC = 32'd8
) (
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_pc_en,
   input  logic [4:2] i_cnt,
   input  logic [3:0] i_cnt_r,
   input  logic       i_cnt_done,
   input  logic       i_jump,
   input  logic       i_jal_or_jalr,
   input  logic       i_utype,
   input  logic       i_pc_rel,
   input  logic       i_trap,
   input  logic       i_imm,
   input  logic       i_buf,
   input  logic       i_csr_pc,
   input  logic       i_ibus_ack,
   output logic       o_rd,
   output logic       o_bad_pc,
   output word_t      o_ibus_adr,
   output logic       o_ibus_cyc
);

   logic fetch_pend;   // set by the shift, cleared by ack
   logic pc;
   logic new_pc;
   logic plus_4;
   logic pc_plus_4;
   logic offset_a;
   logic offset_b;
   logic pc_plus_offset;
   logic pc_plus_offset_aligned;

   assign plus_4 = i_cnt_r[2] && (i_cnt == 3'd0);   // bit 2 only

   ser_add ser_add_pc_plus_4_inst (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc),
      .i_b   (plus_4),
      .i_clr (i_cnt_done),
      .o_q   (pc_plus_4)
   );

   assign offset_a = i_pc_rel & pc;
   // u-type immediates only contribute from bit 12 up
   assign offset_b = i_utype ? (i_imm & (i_cnt[4] | (i_cnt[3:2] == 2'b11))) : i_buf;

   ser_add ser_add_pc_plus_offset_inst (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (offset_a),
      .i_b   (offset_b),
      .i_clr (!i_pc_en),
      .o_q   (pc_plus_offset)
   );

   // fetch_pend is still low on bit 0, which clears the lsb
   assign pc_plus_offset_aligned = pc_plus_offset & fetch_pend;

   always_comb begin
      if (i_trap) begin
         new_pc = i_csr_pc & fetch_pend;
      end else if (i_jump) begin
         new_pc = pc_plus_offset_aligned;
      end else begin
         new_pc = pc_plus_4;
      end
   end

   shift_reg #(
      .LEN  (XLEN),
      .INIT (RESET_PC)
   ) pc_reg_inst (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc),
      .o_par (o_ibus_adr[XLEN-1:1])
   );

   assign o_ibus_adr[0] = pc;

   assign o_rd     = (i_utype & pc_plus_offset_aligned) | (i_jal_or_jalr & pc_plus_4);
   assign o_bad_pc = pc_plus_offset_aligned;

   assign o_ibus_cyc = fetch_pend & !i_pc_en;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         fetch_pend <= 1'b1;   // first fetch out of reset
      end else if (i_pc_en) begin
         fetch_pend <= 1'b1;
      end else if (o_ibus_cyc && i_ibus_ack) begin
         fetch_pend <= 1'b0;
      end
   end

endmodule

/* shift_reg.sv */
module shift_reg #(
   parameter int             LEN  = 32,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_rst,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-2:0] o_par
);

   logic [LEN-1:0] data;

   // new bit enters at the top, lsb leaves first
   always_ff @(posedge clk) begin
      if (i_rst) begin
         data <= INIT;
      end else if (i_en) begin
         data <= {i_d, data[LEN-1:1]};
      end
   end

   assign o_q   = data[0];
   assign o_par = data[LEN-1:1];

endmodule

/* tb_pc_unit.sv */
module tb_pc_unit import pc_pkg::*; ();

   logic  clk;
   logic  i_rst;
   logic  i_start;
   logic  i_jump;
   logic  i_jal_or_jalr;
   logic  i_utype;
   logic  i_pc_rel;
   logic  i_trap;
   word_t i_imm_word;
   word_t i_buf_word;
   word_t i_csr_pc_word;
   logic  i_ibus_ack;
   logic  o_busy;
   logic  o_done;
   word_t o_rd_word;
   logic  o_misaligned;
   word_t o_ibus_adr;
   logic  o_ibus_cyc;
   word_t model_pc;   // pc the next fetch should use
   word_t lfsr;
   word_t got_rd;
   word_t got_adr;
   logic  got_mis;
   int    checks;
   int    errors;
   int    test_errors;
   int    chk_errors;
   bit    hung;          // set once any wait runs out

   pc_unit_top pc_unit_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic word_t lfsr_step(input word_t s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic word_t rand_word();
      word_t w;
      for (int i = 0; i < XLEN; i++) begin
         lfsr = lfsr_step(lfsr);
         w    = {lfsr[0], w[XLEN-1:1]};
      end
      return w;
   endfunction

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (hung) return;
      checks++;
      assert (got === exp)
         else begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
         end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      check_word(what, {31'b0, got}, {31'b0, exp});
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   // one start pulse, then wait for done and keep the results
   task automatic run_instr(input logic jump, input logic jal, input logic utype,
                            input logic pc_rel, input logic trap,
                            input word_t imm, input word_t buf_w, input word_t csr);
      int n;
      if (hung) return;
      @(posedge clk);
      i_start       <= 1'b1;
      i_jump        <= jump;
      i_jal_or_jalr <= jal;
      i_utype       <= utype;
      i_pc_rel      <= pc_rel;
      i_trap        <= trap;
      i_imm_word    <= imm;
      i_buf_word    <= buf_w;
      i_csr_pc_word <= csr;
      @(posedge clk);
      i_start <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!o_done && n < 48);
      if (!o_done) begin
         hung = 1'b1;
         $display("timeout: no done pulse after a start");
      end
      got_rd  = o_rd_word;
      got_mis = o_misaligned;
      got_adr = o_ibus_adr;
      check_bit("cyc at done", o_ibus_cyc, 1'b1);
   endtask

   task automatic ack_fetch();
      int n;
      if (hung) return;
      @(posedge clk);
      i_ibus_ack <= 1'b1;
      @(posedge clk);
      i_ibus_ack <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (o_busy && n < 10);
      if (o_busy) begin
         hung = 1'b1;
         $display("timeout: busy stayed high after the fetch ack");
      end
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_bit("cyc after reset", o_ibus_cyc, 1'b1);
      check_word("adr after reset", o_ibus_adr, model_pc);
      check_bit("busy after reset", o_busy, 1'b1);
      check_bit("done after reset", o_done, 1'b0);
      ack_fetch();
      check_bit("cyc after ack", o_ibus_cyc, 1'b0);
      check_bit("busy after ack", o_busy, 1'b0);
      report_test("reset fetch");
   endtask

   task automatic test_sequential();
      word_t exp;
      word_t noise;
      for (int i = 0; i < 2; i++) begin
         exp   = model_pc + 32'd4;
         noise = rand_word();   // operands the step must ignore
         run_instr(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, noise, noise, noise);
         check_word("next adr", got_adr, exp);
         check_word("rd", got_rd, exp);
         check_bit("misaligned", got_mis, 1'b0);
         model_pc = exp;
         ack_fetch();
      end
      report_test("sequential");
   endtask

   task automatic test_jump();
      word_t offs;
      word_t target;
      for (int i = 0; i < 3; i++) begin
         offs   = rand_word();
         target = (model_pc + offs) & ~32'd1;
         if (target[1] != (i % 2 == 1)) begin   // alternate aligned and misaligned targets
            offs   = offs ^ 32'd2;
            target = (model_pc + offs) & ~32'd1;
         end
         run_instr(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, '0, offs, '0);
         check_word("jump adr", got_adr, target);
         check_word("jump rd", got_rd, model_pc + 32'd4);
         check_bit("misaligned", got_mis, target[1]);
         model_pc = target;
         ack_fetch();
      end
      report_test("pc-relative jump");
   endtask

   task automatic test_utype();
      word_t imm;
      word_t base;
      logic  rel;
      for (int i = 0; i < 2; i++) begin
         rel  = (i == 1);   // lui first, then auipc
         imm  = rand_word();
         base = rel ? model_pc : 32'd0;
         run_instr(1'b0, 1'b0, 1'b1, rel, 1'b0, imm, '0, '0);
         check_word("u-type rd", got_rd, base + (imm & 32'hfffff000));
         check_word("u-type adr", got_adr, model_pc + 32'd4);
         model_pc = model_pc + 32'd4;
         ack_fetch();
      end
      report_test("u-type");
   endtask

   task automatic test_trap();
      word_t vec;
      for (int i = 0; i < 2; i++) begin
         vec = rand_word();
         run_instr(i == 1, 1'b0, 1'b0, 1'b0, 1'b1, '0, rand_word(), vec);
         check_word("trap adr", got_adr, vec & ~32'd1);
         model_pc = vec & ~32'd1;
         ack_fetch();
      end
      report_test("trap");
   endtask

   task automatic test_backpressure();
      word_t exp;
      exp = model_pc + 32'd4;
      run_instr(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
      check_word("adr before stall", got_adr, exp);
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         i_start       <= (i == 2);   // must be dropped, fetch still pending
         i_trap        <= 1'b1;
         i_csr_pc_word <= rand_word();
         @(negedge clk);
         check_bit("cyc during stall", o_ibus_cyc, 1'b1);
         check_word("adr during stall", o_ibus_adr, exp);
         check_bit("busy during stall", o_busy, 1'b1);
         check_bit("done during stall", o_done, 1'b0);
      end
      ack_fetch();
      check_word("rd after stall", o_rd_word, exp);
      check_bit("misaligned after stall", o_misaligned, 1'b0);
      model_pc = exp;
      run_instr(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
      check_word("adr after dropped start", got_adr, model_pc + 32'd4);
      model_pc = model_pc + 32'd4;
      ack_fetch();
      report_test("back-pressure");
   endtask

   initial begin
      i_rst         <= 1'b1;
      i_start       <= 1'b0;
      i_jump        <= 1'b0;
      i_jal_or_jalr <= 1'b0;
      i_utype       <= 1'b0;
      i_pc_rel      <= 1'b0;
      i_trap        <= 1'b0;
      i_imm_word    <= '0;
      i_buf_word    <= '0;
      i_csr_pc_word <= '0;
      i_ibus_ack    <= 1'b0;
      model_pc    = 32'd8;   // default RESET_PC of the top level
      lfsr        = 32'd22;
      checks      = 0;
      errors      = 0;
      test_errors = 0;
      hung        = 1'b0;
      repeat (3) @(posedge clk);
      i_rst <= 1'b0;
      test_reset();
      test_sequential();
      test_jump();
      test_utype();
      test_trap();
      test_backpressure();
      chk_errors = pc_unit_top_inst.pc_unit_chk_inst.err_cnt;
      if (hung) $display("run stopped early because a wait timed out");
      $display("checks %0d, failed %0d, bound assertion errors %0d", checks, errors, chk_errors);
      if (errors == 0 && chk_errors == 0 && !hung) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
